// File: design/palette_defs.svh
// Size and register-map macros for the palette stage, included by every file that needs a width.
`ifndef PALETTE_DEFS_SVH
`define PALETTE_DEFS_SVH

// ======================================================================
// PROM geometry
// ======================================================================
`define PROM_AW      8          // Each colour PROM holds 256 entries.
`define PROM_DW      4          // One colour nibble per entry.
`define NUM_PROMS    3          // Red, green and blue, in that order.

// ======================================================================
// APB bus and register map
// ======================================================================
`define APB_AW       12         // Region, reserved and offset fields.
`define APB_WDW      8          // Write data byte; the PROMs keep the low nibble.
`define CSUM_W       16         // Checksum width, also the read data width.

`define REGION_CTRL  2'd3       // Regions 0 to 2 are the PROMs themselves.
`define REG_CHECKSUM 8'h00      // Read returns the checksum, write clears it.

`endif

// File: design/palette_lookup.sv
// Two-stage pixel pipeline turning a colour index into 12-bit RGB; instantiated by palette_top.
`default_nettype none

`include "palette_defs.svh"

module palette_lookup
    import palette_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,            // Synchronous, active high.
    input  wire logic     pix_cen,          // Pixel clock enable, stalls when low.
    input  wire logic     pix_valid,        // Marks a real pixel on the input.
    input  wire pixel_t   pixel,            // Blank flag and colour index.
    input  wire prom_wr_t prom_wr,          // Download writes from the loader.
    output logic          rgb_valid,        // High for one cycle per real pixel.
    output rgb_t          rgb               // Registered colour, black when blanked.
);

    // ==================================================================
    // Stage 1, the PROM read
    // ==================================================================
    logic [`PROM_DW-1:0] prom_q [`NUM_PROMS];  // Red, green and blue read data.
    logic                s1_valid;             // Pixel valid beside the PROM read.
    logic                s1_blank;             // Blank flag beside the PROM read.
    rgb_t                colour;               // Stage 2 input after blanking.

    // All three PROMs share the read index and the write address.
    // Only the strobe bit differs between them.
    for (genvar i = 0; i < `NUM_PROMS; i++) begin : g_prom
        prom_mem #(
            .aw      (`PROM_AW),
            .dw      (`PROM_DW)
        ) u_prom (
            .clk     (clk),
            .cen     (pix_cen),
            .wr_addr (prom_wr.addr),
            .wr_data (prom_wr.data),
            .we      (prom_wr.we[i]),
            .rd_addr (pixel.index),
            .q       (prom_q[i])
        );
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (pix_cen) begin
            s1_valid <= pix_valid;          // Moves with the PROM read.
        end
    end

    always_ff @(posedge clk) begin
        if (pix_cen) begin
            s1_blank <= pixel.blank;
        end
    end

    // ==================================================================
    // Stage 2, the output register
    // ==================================================================
    always_comb begin
        if (s1_blank) begin
            colour = '0;                    // Blanking wins over the PROM data.
        end else begin
            colour = '{r: prom_q[0], g: prom_q[1], b: prom_q[2]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= pix_cen & s1_valid;    // Low on every stalled edge.
        end
    end

    always_ff @(posedge clk) begin
        if (pix_cen) begin
            rgb <= colour;                  // Holds the last colour during a stall.
        end
    end

endmodule

`default_nettype wire

// File: design/palette_pkg.sv
// Shared bus, write and pixel types for the palette stage; import wherever a port uses them.
`default_nettype none

`include "palette_defs.svh"

package palette_pkg;

    // ==================================================================
    // APB slave interface
    // ==================================================================
    typedef struct packed {
        logic [`APB_AW-1:0]  paddr;     // Byte address into one of four regions.
        logic                psel;      // High for setup and access phases.
        logic                penable;   // High in the access phase only.
        logic                pwrite;    // High for a write transfer.
        logic [`APB_WDW-1:0] pwdata;    // Low nibble goes to the PROM.
    } apb_req_t;

    typedef struct packed {
        logic [`CSUM_W-1:0]  prdata;    // Checksum or zero.
        logic                pready;    // Tied high, there are no wait states.
        logic                pslverr;   // Set for accesses the slave rejects.
    } apb_rsp_t;

    // Field view of the APB address; the reserved bits are not decoded.
    typedef struct packed {
        logic [1:0]          region;    // PROM select, or the control region.
        logic [1:0]          rsvd;      // Ignored by the decoder.
        logic [`PROM_AW-1:0] offset;    // PROM entry or control register.
    } apb_addr_fields_t;

    typedef union packed {
        logic [`APB_AW-1:0]  raw;       // The whole address as one word.
        apb_addr_fields_t    fld;       // The same word split for decoding.
    } apb_addr_u;

    // ==================================================================
    // PROM write port and video data
    // ==================================================================
    typedef struct packed {
        logic [`NUM_PROMS-1:0] we;      // One-hot, bit 0 is the red PROM.
        logic [`PROM_AW-1:0]   addr;    // Entry to write.
        logic [`PROM_DW-1:0]   data;    // Colour nibble to store.
    } prom_wr_t;

    typedef struct packed {
        logic                blank;     // Forces black at the output.
        logic [`PROM_AW-1:0] index;     // Colour index into all three PROMs.
    } pixel_t;

    typedef struct packed {
        logic [`PROM_DW-1:0] r;
        logic [`PROM_DW-1:0] g;
        logic [`PROM_DW-1:0] b;
    } rgb_t;

endpackage

`default_nettype wire

// File: design/palette_top.sv
// Top level of the palette stage, joining the APB PROM loader to the pixel lookup pipeline.
`default_nettype none

module palette_top
    import palette_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,            // Synchronous, active high.

    // ==================================================================
    // APB download port
    // ==================================================================
    input  wire apb_req_t apb_req,          // From the download master.
    output apb_rsp_t      apb_rsp,          // Zero wait states.

    // ==================================================================
    // Video port
    // ==================================================================
    input  wire logic     pix_cen,          // Pixel clock enable.
    input  wire logic     pix_valid,        // Real pixel on the input.
    input  wire pixel_t   pixel,            // Blank flag and colour index.
    output logic          rgb_valid,        // Colour valid, two enabled edges later.
    output rgb_t          rgb               // 12-bit colour.
);

    prom_wr_t prom_wr;                      // Loader to PROM write strobe and data.

    // The loader owns the APB side and the checksum.
    prom_loader u_loader (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .prom_wr   (prom_wr)
    );

    // The lookup owns the three PROMs.
    // It takes downloads at any time, whatever the state of pix_cen.
    palette_lookup u_lookup (
        .clk       (clk),
        .reset     (reset),
        .pix_cen   (pix_cen),
        .pix_valid (pix_valid),
        .pixel     (pixel),
        .prom_wr   (prom_wr),
        .rgb_valid (rgb_valid),
        .rgb       (rgb)
    );

endmodule

`default_nettype wire

// File: design/prom_loader.sv
// APB slave that downloads the colour PROMs and keeps a running checksum; sits under palette_top.
`default_nettype none

`include "palette_defs.svh"

module prom_loader
    import palette_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,            // Synchronous, active high.
    input  wire apb_req_t apb_req,          // Request from the APB master.
    output apb_rsp_t      apb_rsp,          // Response, valid in the access phase.
    output prom_wr_t      prom_wr           // One-cycle write to the PROMs.
);

    localparam int csum_pad = `CSUM_W - `PROM_DW;   // Zero bits above the nibble.

    // ==================================================================
    // Address decode
    // ==================================================================
    apb_addr_u             req_addr;        // Current APB address, both views.
    logic                  setup_ph;        // First cycle of a transfer.
    logic                  access_ph;       // Second and last cycle.
    logic                  is_ctrl;         // Address is in the control region.
    logic                  is_csum_reg;     // Address is the checksum register.
    logic [`NUM_PROMS-1:0] we_onehot;       // PROM selected by the region field.
    logic [`PROM_DW-1:0]   wr_nibble;       // The part of pwdata that is stored.

    logic [`CSUM_W-1:0]    csum;            // Running sum of downloaded nibbles.
    logic [`CSUM_W-1:0]    prdata_q;        // Read data held through the access phase.
    logic                  pslverr_q;       // Error flag held through the access phase.
    logic [`NUM_PROMS-1:0] wr_we;           // Registered write strobes.
    logic [`PROM_AW-1:0]   wr_addr;         // Registered write address.
    logic [`PROM_DW-1:0]   wr_data;         // Registered write nibble.

    always_comb begin
        req_addr.raw = apb_req.paddr;       // Load the word, decode through fields.
    end

    assign setup_ph    = apb_req.psel & ~apb_req.penable;
    assign access_ph   = apb_req.psel &  apb_req.penable;
    assign is_ctrl     = (req_addr.fld.region == `REGION_CTRL);
    assign is_csum_reg = is_ctrl && (req_addr.fld.offset == `REG_CHECKSUM);
    assign wr_nibble   = apb_req.pwdata[`PROM_DW-1:0];

    // Region 0 to 2 maps straight onto a strobe bit.
    always_comb begin
        we_onehot = '0;
        if (!is_ctrl) begin
            we_onehot[req_addr.fld.region] = 1'b1;
        end
    end

    // ==================================================================
    // Response
    // ==================================================================
    // The response is prepared on the setup edge so that it is stable for the
    // whole access phase, when the master samples it.
    always_ff @(posedge clk) begin
        if (reset) begin
            pslverr_q <= 1'b0;
        end else if (setup_ph) begin
            // PROMs are write-only, and the control region has one register.
            pslverr_q <= is_ctrl ? !is_csum_reg : !apb_req.pwrite;
        end else if (access_ph) begin
            pslverr_q <= 1'b0;              // Drop the flag as the transfer ends.
        end
    end

    always_ff @(posedge clk) begin
        if (setup_ph) begin
            prdata_q <= (is_csum_reg && !apb_req.pwrite) ? csum : '0;
        end
    end

    // ==================================================================
    // Checksum
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            csum <= '0;
        end else if (access_ph && apb_req.pwrite) begin
            if (is_csum_reg) begin
                csum <= '0;                 // Software restarts the count.
            end else if (!is_ctrl) begin
                csum <= csum + {{csum_pad{1'b0}}, wr_nibble};   // Wraps at 16 bits.
            end
        end
    end

    // ==================================================================
    // PROM write port
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_we <= '0;
        end else begin
            wr_we <= (access_ph && apb_req.pwrite) ? we_onehot : '0;   // One cycle only.
        end
    end

    always_ff @(posedge clk) begin
        if (access_ph) begin
            wr_addr <= req_addr.fld.offset; // Reserved bits play no part.
            wr_data <= wr_nibble;
        end
    end

    assign apb_rsp = '{prdata: prdata_q, pready: 1'b1, pslverr: pslverr_q};
    assign prom_wr = '{we: wr_we, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// File: design/prom_mem.sv
// One colour PROM with a free-running write port and an enabled read port; used by the lookup.
`default_nettype none

`include "palette_defs.svh"

module prom_mem #(
    parameter int aw = `PROM_AW,            // Address width, 2**aw entries.
    parameter int dw = `PROM_DW             // Entry width.
) (
    input  wire logic          clk,
    input  wire logic          cen,         // Pixel clock enable, gates reads only.
    input  wire logic [aw-1:0] wr_addr,     // Download address.
    input  wire logic [dw-1:0] wr_data,     // Download nibble.
    input  wire logic          we,          // Download strobe.
    input  wire logic [aw-1:0] rd_addr,     // Pixel colour index.
    output logic      [dw-1:0] q            // Registered colour nibble.
);

    // ==================================================================
    // Storage
    // ==================================================================
    logic [dw-1:0] mem [0:(1 << aw) - 1];   // Contents are undefined until downloaded.

    // The write side never looks at cen.
    // A download therefore lands even while video is stopped.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;        // Store on any edge with the strobe up.
        end
    end

    // ==================================================================
    // Read port
    // ==================================================================
    // The read advances with the pixel pipeline and holds while cen is low.
    // A read and a write to the same entry on one edge return the old value.
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];              // One enabled edge of read latency.
        end
    end

endmodule

`default_nettype wire

// File: sim/palette_asserts.sv
// Concurrent checks on APB and pixel timing, bound into palette_top for simulation runs.
`default_nettype none

module palette_asserts
    import palette_pkg::*;
(
    input wire logic     clk,
    input wire logic     reset,             // Synchronous, active high.
    input wire apb_req_t apb_req,           // Request as seen by the loader.
    input wire apb_rsp_t apb_rsp,           // Response from the loader.
    input wire logic     pix_cen,           // Pixel clock enable.
    input wire logic     rgb_valid,         // Output colour valid.
    input wire prom_wr_t prom_wr            // Internal loader to PROM write.
);

    int fail_count = 0;                     // Failed assertions, read by the testbench.

    // ==================================================================
    // APB
    // ==================================================================
    // The slave has no wait states, so the access phase always completes.
    a_pready : assert property (@(posedge clk) disable iff (reset)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else begin
            fail_count++;
            $error("pready was low in an APB access phase");
        end

    // ==================================================================
    // Pixel pipeline
    // ==================================================================
    // The output register only loads on an enabled edge.
    // A valid colour therefore implies pix_cen was high one edge earlier.
    a_valid_needs_cen : assert property (@(posedge clk) disable iff (reset)
        rgb_valid |-> $past(pix_cen))
        else begin
            fail_count++;
            $error("rgb_valid rose after an edge with pix_cen low");
        end

    // ==================================================================
    // PROM write port
    // ==================================================================
    // The region field selects one PROM, never two.
    a_we_onehot : assert property (@(posedge clk) disable iff (reset)
        $onehot0(prom_wr.we))
        else begin
            fail_count++;
            $error("more than one PROM write enable was high");
        end

endmodule

// Attach to every palette_top, reaching its internal write bus.
bind palette_top palette_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .pix_cen   (pix_cen),
    .rgb_valid (rgb_valid),
    .prom_wr   (prom_wr)
);

`default_nettype wire

// File: sim/palette_tb.sv
// Testbench for the palette stage; downloads the PROMs over APB, then runs pixels and checks RGB.
`default_nettype none

`include "palette_defs.svh"

module palette_tb
    import palette_pkg::*;
();

    // ==================================================================
    // Run length and watchdog budget
    // ==================================================================
    localparam int n_rand      = 300;       // Unblanked pixels, no gaps.
    localparam int n_blank     = 64;        // Blanked pixels.
    localparam int n_gap       = 300;       // Pixels under random stalls.
    localparam int gap_pct     = 40;        // Chance of pix_cen low per cycle.
    localparam int n_partial   = 16;        // Writes in the partial download.
    localparam int drain_limit = 16;        // Cycles allowed to empty the pipe.
    localparam int apb_cycles  = 3 * (3 * 256 + 2 + 12 + n_partial + 3);
    localparam int pix_cycles  = n_rand + n_blank + 4 * n_gap + n_partial + 4 * (drain_limit + 3);
    localparam int watchdog_cycles = 2 * (5 + apb_cycles + pix_cycles) + 500;

    logic     clk = 1'b0;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     pix_cen;
    logic     pix_valid;
    pixel_t   pixel;
    logic     rgb_valid;
    rgb_t     rgb;

    logic [`PROM_DW-1:0] prom_model [0:`NUM_PROMS-1][0:(1 << `PROM_AW)-1];  // Every write.
    logic [`PROM_DW-1:0] csum_log [$];      // Nibbles written since the last clear.
    logic [`PROM_AW-1:0] idx_list [$];      // Entries rewritten in the partial download.
    rgb_t                exp_q [$];         // Expected colours in input order.
    int                  tag_q [$];         // Enabled edge that took each pixel.
    int                  en_count = 0;      // Enabled edges so far.
    int                  error_count = 0;
    int                  test_count = 0;
    int                  failed_tests = 0;
    int                  test_start_errors;
    string               test_name;
    rgb_t                exp_rgb;
    int                  exp_tag;

    palette_top dut (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .pix_cen   (pix_cen),
        .pix_valid (pix_valid),
        .pixel     (pixel),
        .rgb_valid (rgb_valid),
        .rgb       (rgb)
    );

    always #10 clk = ~clk;                  // Period of 20.

    // ==================================================================
    // Reference model
    // ==================================================================
    function automatic rgb_t expect_rgb(input pixel_t p);
        rgb_t c;
        c = '{r: prom_model[0][p.index], g: prom_model[1][p.index], b: prom_model[2][p.index]};
        return p.blank ? rgb_t'('0) : c;    // Blank forces black.
    endfunction

    function automatic logic [`CSUM_W-1:0] expect_csum();
        logic [`CSUM_W-1:0] sum;
        sum = '0;
        foreach (csum_log[i]) begin
            sum = sum + csum_log[i];        // Zero-extended, wraps at 16 bits.
        end
        return sum;
    endfunction

    // Procedural errors plus failures of the bound assertions.
    function automatic int total_errors();
        return error_count + dut.u_asserts.fail_count;
    endfunction

    // ==================================================================
    // Compare tasks
    // ==================================================================
    task automatic check_rgb(input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR t=%0t rgb: got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input int left);
        if (left != 0) begin
            error_count++;
            $display("At t=%0t, %0d expected pixels never came out of the pipeline.", $time, left);
        end
    endtask

    // ==================================================================
    // APB driver
    // ==================================================================
    // Setup, access, then one idle cycle so psel drops between transfers.
    task automatic apb_transfer(input logic [`APB_AW-1:0] addr, input logic wr,
                                input logic [`APB_WDW-1:0] data, input apb_rsp_t exp);
        @(posedge clk);
        #2;
        apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: data};
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        check_rsp(wr ? "apb_rsp write" : "apb_rsp read", apb_rsp, exp);   // Set on setup edge.
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [`APB_WDW-1:0] data);
        apb_rsp_t exp;
        exp = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};
        if (addr[11:10] != `REGION_CTRL) begin
            prom_model[addr[11:10]][addr[7:0]] = data[3:0];
            csum_log.push_back(data[3:0]);
        end else if (addr[7:0] == `REG_CHECKSUM) begin
            csum_log.delete();              // Checksum restarts from zero.
        end else begin
            exp.pslverr = 1'b1;             // Unknown control register.
        end
        apb_transfer(addr, 1'b1, data, exp);
    endtask

    task automatic apb_read(input logic [`APB_AW-1:0] addr);
        apb_rsp_t exp;
        exp = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};
        if (addr[11:10] == `REGION_CTRL && addr[7:0] == `REG_CHECKSUM) begin
            exp.prdata  = expect_csum();
            exp.pslverr = 1'b0;
        end
        apb_transfer(addr, 1'b0, 8'h00, exp);
    endtask

    // ==================================================================
    // Pixel driver
    // ==================================================================
    task automatic send_pixel(input pixel_t p, input logic valid, input int gap);
        logic taken;
        taken = 1'b0;
        while (!taken) begin                // Hold the pixel until an enabled edge.
            @(posedge clk);
            #2;
            pix_cen   = ($urandom_range(99) >= gap);
            pix_valid = valid;
            pixel     = p;
            taken     = pix_cen;
        end
    endtask

    task automatic drain_pipe();
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        pix_cen   = 1'b1;
        pix_valid = 1'b0;
        while (exp_q.size() != 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        repeat (3) @(posedge clk);          // Catch any extra output.
        check_count(exp_q.size());
    endtask

    task automatic begin_test(input string name);
        test_name         = name;
        test_start_errors = total_errors();
    endtask

    task automatic end_test();
        int errs;
        errs = total_errors() - test_start_errors;
        test_count++;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("Test %0d %s: %s with %0d errors", test_count, test_name,
                 (errs == 0) ? "ok" : "bad", errs);
    endtask

    // ==================================================================
    // Compare process
    // ==================================================================
    // Sampled on the falling edge, away from both the DUT edge and the drive.
    always @(negedge clk) begin
        if (!reset) begin
            if (rgb_valid) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("At t=%0t, rgb_valid was high with no pixel in flight.", $time);
                end else begin
                    exp_rgb = exp_q.pop_front();
                    exp_tag = tag_q.pop_front();
                    check_rgb(rgb, exp_rgb);
                    if (en_count != exp_tag + 1) begin
                        error_count++;
                        $display("ERROR t=%0t rgb latency: got edge %0d expected %0d",
                                 $time, en_count, exp_tag + 1);
                    end
                end
            end
            if (pix_cen) begin
                en_count++;                 // The coming edge is enabled.
                if (pix_valid) begin
                    exp_q.push_back(expect_rgb(pixel));
                    tag_q.push_back(en_count);
                end
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles and the run did not finish.", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        logic [1:0] sel;
        logic [7:0] off;
        void'($urandom(32'h285568a1));
        reset     = 1'b1;
        apb_req   = '0;
        pix_cen   = 1'b0;
        pix_valid = 1'b0;
        pixel     = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        begin_test("full download and checksum");
        for (int r = 0; r < `NUM_PROMS; r++) begin
            for (int o = 0; o < 256; o++) begin
                apb_write({r[1:0], 2'b00, o[7:0]}, 8'($urandom_range(255)));
            end
        end
        apb_read({`REGION_CTRL, 2'b00, `REG_CHECKSUM});
        end_test();

        begin_test("unblanked lookups");
        repeat (n_rand) send_pixel('{blank: 1'b0, index: 8'($urandom_range(255))}, 1'b1, 0);
        drain_pipe();
        end_test();

        begin_test("blanked lookups");
        repeat (n_blank) send_pixel('{blank: 1'b1, index: 8'($urandom_range(255))}, 1'b1, 0);
        drain_pipe();
        end_test();

        begin_test("pix_cen gaps");
        repeat (n_gap) begin
            send_pixel('{blank: ($urandom_range(7) == 0), index: 8'($urandom_range(255))},
                       ($urandom_range(9) != 0), gap_pct);
        end
        drain_pipe();
        end_test();

        begin_test("rejected accesses");
        for (int r = 0; r < `NUM_PROMS; r++) begin
            apb_read({r[1:0], 2'b00, 8'($urandom_range(255))});
        end
        repeat (3) begin
            off = 8'(1 + $urandom_range(254));
            apb_read({`REGION_CTRL, 2'b00, off});
            apb_write({`REGION_CTRL, 2'b00, off}, 8'($urandom_range(255)));
        end
        apb_read({`REGION_CTRL, 2'b00, `REG_CHECKSUM});
        end_test();

        begin_test("clear and partial download");
        apb_write({`REGION_CTRL, 2'b00, `REG_CHECKSUM}, 8'($urandom_range(255)));
        apb_read({`REGION_CTRL, 2'b00, `REG_CHECKSUM});
        repeat (n_partial) begin
            sel = 2'($urandom_range(2));
            off = 8'($urandom_range(255));
            idx_list.push_back(off);
            apb_write({sel, 2'b00, off}, 8'($urandom_range(255)));
        end
        apb_read({`REGION_CTRL, 2'b00, `REG_CHECKSUM});
        foreach (idx_list[i]) begin
            send_pixel('{blank: 1'b0, index: idx_list[i]}, 1'b1, 0);
        end
        drain_pipe();
        end_test();

        $display("Tests run %0d, tests failed %0d, errors %0d", test_count, failed_tests,
                 total_errors());
        if (total_errors() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/palette_pkg.sv
design/prom_mem.sv
design/prom_loader.sv
design/palette_lookup.sv
design/palette_top.sv
sim/palette_asserts.sv
sim/palette_tb.sv
